// ==== include/streamer_consts.svh ====
// --------------------
// Streamer constants
// Widths, channel count and FIFO depths
// --------------------
`ifndef STREAMER_CONSTS_SVH
`define STREAMER_CONSTS_SVH

// Memory and stream word width
`define STREAMER_DATA_W 32
// Byte address width
`define STREAMER_ADDR_W 32
`define STREAMER_LEN_W 16

// Three loads and one store share the memory port
`define STREAMER_N_CH 4

`define STREAMER_LOAD_DEPTH 4
`define STREAMER_STORE_DEPTH 2

`endif

// ==== rtl/streamer_pkg.sv ====
// --------------------
// Streamer types
// Memory port, channel config and store queue items
// --------------------
`include "streamer_consts.svh"

package streamer_pkg;

  typedef logic [`STREAMER_DATA_W-1:0] data_t;
  typedef logic [`STREAMER_ADDR_W-1:0] addr_t;
  typedef logic [`STREAMER_LEN_W-1:0]  len_t;

  typedef logic [$clog2(`STREAMER_N_CH)-1:0] ch_idx_t;

  // Channel slots on the arbiter
  localparam ch_idx_t CH_X = 2'd0;
  localparam ch_idx_t CH_W = 2'd1;
  localparam ch_idx_t CH_Y = 2'd2;
  localparam ch_idx_t CH_Z = 2'd3;

  // Stride is in bytes, length in words
  typedef struct packed {
    addr_t base;
    addr_t stride;
    len_t  len;
  } ch_cfg_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

  // One pending write of the store channel
  typedef struct packed {
    addr_t addr;
    data_t wdata;
  } store_item_t;

endpackage

// ==== rtl/stream_fifo.sv ====
// --------------------
// Stream FIFO
// Circular buffer of any packed item with a free-slot count
// --------------------
`timescale 1ns/1ps

module stream_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned DEPTH  = 4,
  localparam int unsigned CNT_W = $clog2(DEPTH + 1),
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  item_t            item_i,
  output logic             full_o,
  input  logic             pop_i,
  output item_t            item_o,
  output logic             empty_o,
  output logic [CNT_W-1:0] free_o
);

  item_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_en;
  logic             pop_en;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign free_o  = CNT_W'(DEPTH) - count_q;
  assign item_o  = mem_q[rd_ptr_q];

  // A full FIFO still takes a push when the head leaves in the same cycle
  assign pop_en  = pop_i && !empty_o;
  assign push_en = push_i && (!full_o || pop_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

endmodule

// ==== rtl/load_source.sv ====
// --------------------
// Load source
// Strided reads from memory turned into an in-order stream
// --------------------
`timescale 1ns/1ps
`include "streamer_consts.svh"

module load_source (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  streamer_pkg::ch_cfg_t cfg_i,
  output logic                  req_o,
  output streamer_pkg::mem_req_t req_o_data,
  input  logic                  gnt_i,
  input  streamer_pkg::mem_rsp_t rsp_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output streamer_pkg::data_t   data_o,
  output logic                  done_o
);

  import streamer_pkg::*;

  localparam int unsigned CNT_W = $clog2(`STREAMER_LOAD_DEPTH + 1);

  logic             busy_q;
  logic             done_q;
  len_t             req_left_q;
  len_t             out_left_q;
  addr_t            addr_q;
  addr_t            stride_q;
  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W-1:0] fifo_free;
  logic             fifo_empty;
  logic             start_ok;
  logic             req_fire;
  logic             pop;

  assign start_ok = start_i && !busy_q;
  assign req_fire = req_o && gnt_i;
  assign pop      = valid_o && ready_i;

  // Only ask for a word when a FIFO slot is already reserved for it
  assign req_o = busy_q && (req_left_q != '0) && (fifo_free > inflight_q);

  assign req_o_data.addr  = addr_q;
  assign req_o_data.we    = 1'b0;
  assign req_o_data.wdata = '0;

  assign valid_o = !fifo_empty;
  assign done_o  = done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      req_left_q <= '0;
      out_left_q <= '0;
      inflight_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_ok) begin
        busy_q     <= (cfg_i.len != '0);
        done_q     <= (cfg_i.len == '0);
        req_left_q <= cfg_i.len;
        out_left_q <= cfg_i.len;
      end else begin
        if (req_fire) begin
          req_left_q <= req_left_q - 1'b1;
        end
        if (pop) begin
          out_left_q <= out_left_q - 1'b1;
          // last word out
          if (out_left_q == len_t'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
      // Reads granted but whose data is not yet in the FIFO
      if (req_fire && !rsp_i.rvalid) begin
        inflight_q <= inflight_q + 1'b1;
      end else if (!req_fire && rsp_i.rvalid) begin
        inflight_q <= inflight_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      addr_q   <= cfg_i.base;
      stride_q <= cfg_i.stride;
    end else if (req_fire) begin
      addr_q <= addr_q + stride_q;
    end
  end

  stream_fifo #(
    .item_t (data_t),
    .DEPTH  (`STREAMER_LOAD_DEPTH)
  ) i_load_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rsp_i.rvalid),
    .item_i  (rsp_i.rdata),
    .full_o  (),
    .pop_i   (pop),
    .item_o  (data_o),
    .empty_o (fifo_empty),
    .free_o  (fifo_free)
  );

endmodule

// ==== rtl/store_sink.sv ====
// --------------------
// Store sink
// Stream words paired with strided addresses and written out
// --------------------
`timescale 1ns/1ps
`include "streamer_consts.svh"

module store_sink (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  streamer_pkg::ch_cfg_t  cfg_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  streamer_pkg::data_t    data_i,
  output logic                   req_o,
  output streamer_pkg::mem_req_t req_o_data,
  input  logic                   gnt_i,
  output logic                   done_o
);

  import streamer_pkg::*;

  logic        busy_q;
  logic        done_q;
  len_t        acc_left_q;
  len_t        wr_left_q;
  addr_t       addr_q;
  addr_t       stride_q;
  store_item_t push_item;
  store_item_t head;
  logic        fifo_full;
  logic        fifo_empty;
  logic        start_ok;
  logic        push;
  logic        wr_fire;

  assign start_ok = start_i && !busy_q;
  assign ready_o  = busy_q && (acc_left_q != '0) && !fifo_full;
  assign push     = valid_i && ready_o;
  assign wr_fire  = req_o && gnt_i;

  assign push_item.addr  = addr_q;
  assign push_item.wdata = data_i;

  // Writes go out straight from the FIFO head
  assign req_o            = !fifo_empty;
  assign req_o_data.addr  = head.addr;
  assign req_o_data.we    = 1'b1;
  assign req_o_data.wdata = head.wdata;
  assign done_o           = done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      acc_left_q <= '0;
      wr_left_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_ok) begin
        busy_q     <= (cfg_i.len != '0);
        done_q     <= (cfg_i.len == '0);
        acc_left_q <= cfg_i.len;
        wr_left_q  <= cfg_i.len;
      end else begin
        if (push) begin
          acc_left_q <= acc_left_q - 1'b1;
        end
        if (wr_fire) begin
          wr_left_q <= wr_left_q - 1'b1;
          if (wr_left_q == len_t'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      addr_q   <= cfg_i.base;
      stride_q <= cfg_i.stride;
    end else if (push) begin
      addr_q <= addr_q + stride_q;
    end
  end

  stream_fifo #(
    .item_t (store_item_t),
    .DEPTH  (`STREAMER_STORE_DEPTH)
  ) i_store_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .item_i  (push_item),
    .full_o  (fifo_full),
    .pop_i   (wr_fire),
    .item_o  (head),
    .empty_o (fifo_empty),
    .free_o  ()
  );

endmodule

// ==== rtl/tcdm_arbiter.sv ====
// --------------------
// TCDM arbiter
// Round-robin of all channels onto one memory port
// --------------------
`timescale 1ns/1ps
`include "streamer_consts.svh"

module tcdm_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic [`STREAMER_N_CH-1:0]                   req_i,
  input  streamer_pkg::mem_req_t [`STREAMER_N_CH-1:0] req_data_i,
  output logic [`STREAMER_N_CH-1:0]                   gnt_o,
  output streamer_pkg::mem_rsp_t [`STREAMER_N_CH-1:0] rsp_o,
  output logic                                        mem_req_o,
  output streamer_pkg::mem_req_t                      mem_req_data_o,
  input  logic                                        mem_gnt_i,
  input  streamer_pkg::mem_rsp_t                      mem_rsp_i
);

  import streamer_pkg::*;

  localparam int unsigned N_CH = `STREAMER_N_CH;

  ch_idx_t last_q;
  ch_idx_t rr_sel;
  ch_idx_t idx;
  ch_idx_t sel;
  logic    found;
  logic    hold_q;
  ch_idx_t hold_idx_q;
  logic    rd_pend_q;
  ch_idx_t rd_idx_q;
  logic    mem_fire;

  // First requester after the last granted channel
  always_comb begin
    found  = 1'b0;
    rr_sel = last_q;
    idx    = last_q;
    for (int unsigned off = 1; off <= N_CH; off++) begin
      idx = ch_idx_t'((int'(last_q) + off) % N_CH);
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        rr_sel = idx;
      end
    end
  end

  // A stalled request keeps the port until granted, so the payload stays stable
  assign sel            = hold_q ? hold_idx_q : rr_sel;
  assign mem_req_o      = found;
  assign mem_req_data_o = req_data_i[sel];
  assign mem_fire       = mem_req_o && mem_gnt_i;

  always_comb begin
    gnt_o = '0;
    if (mem_fire) begin
      gnt_o[sel] = 1'b1;
    end
  end

  // Read data goes back only to the channel whose read was granted
  always_comb begin
    for (int unsigned i = 0; i < N_CH; i++) begin
      rsp_o[i].rvalid = mem_rsp_i.rvalid && rd_pend_q && (rd_idx_q == ch_idx_t'(i));
      rsp_o[i].rdata  = mem_rsp_i.rdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q    <= '0;
      hold_q    <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      hold_q    <= mem_req_o && !mem_gnt_i;
      rd_pend_q <= mem_fire && !mem_req_data_o.we;
      if (mem_fire) begin
        last_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    hold_idx_q <= sel;
    rd_idx_q   <= sel;
  end

endmodule

// ==== rtl/redmule_streamer.sv ====
// --------------------
// Matrix-engine streamer
// X, W, Y loads and Z store on one memory port
// --------------------
`timescale 1ns/1ps
`include "streamer_consts.svh"

module redmule_streamer (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // X load stream
  input  logic                   x_start_i,
  input  streamer_pkg::ch_cfg_t  x_cfg_i,
  output logic                   x_valid_o,
  input  logic                   x_ready_i,
  output streamer_pkg::data_t    x_data_o,
  output logic                   x_done_o,
  // W load stream
  input  logic                   w_start_i,
  input  streamer_pkg::ch_cfg_t  w_cfg_i,
  output logic                   w_valid_o,
  input  logic                   w_ready_i,
  output streamer_pkg::data_t    w_data_o,
  output logic                   w_done_o,
  // Y load stream
  input  logic                   y_start_i,
  input  streamer_pkg::ch_cfg_t  y_cfg_i,
  output logic                   y_valid_o,
  input  logic                   y_ready_i,
  output streamer_pkg::data_t    y_data_o,
  output logic                   y_done_o,
  // Z store stream
  input  logic                   z_start_i,
  input  streamer_pkg::ch_cfg_t  z_cfg_i,
  input  logic                   z_valid_i,
  output logic                   z_ready_o,
  input  streamer_pkg::data_t    z_data_i,
  output logic                   z_done_o,
  // Memory port
  output logic                   mem_req_o,
  output streamer_pkg::mem_req_t mem_req_data_o,
  input  logic                   mem_gnt_i,
  input  streamer_pkg::mem_rsp_t mem_rsp_i
);

  import streamer_pkg::*;

  logic     [`STREAMER_N_CH-1:0] ch_req;
  logic     [`STREAMER_N_CH-1:0] ch_gnt;
  mem_req_t [`STREAMER_N_CH-1:0] ch_req_data;
  mem_rsp_t [`STREAMER_N_CH-1:0] ch_rsp;

  load_source i_x_source (
    .clk_i   (clk_i),     .rst_n_i    (rst_n_i),
    .start_i (x_start_i), .cfg_i      (x_cfg_i),
    .req_o   (ch_req[CH_X]), .req_o_data (ch_req_data[CH_X]),
    .gnt_i   (ch_gnt[CH_X]), .rsp_i      (ch_rsp[CH_X]),
    .valid_o (x_valid_o), .ready_i    (x_ready_i),
    .data_o  (x_data_o),  .done_o     (x_done_o)
  );

  load_source i_w_source (
    .clk_i   (clk_i),     .rst_n_i    (rst_n_i),
    .start_i (w_start_i), .cfg_i      (w_cfg_i),
    .req_o   (ch_req[CH_W]), .req_o_data (ch_req_data[CH_W]),
    .gnt_i   (ch_gnt[CH_W]), .rsp_i      (ch_rsp[CH_W]),
    .valid_o (w_valid_o), .ready_i    (w_ready_i),
    .data_o  (w_data_o),  .done_o     (w_done_o)
  );

  load_source i_y_source (
    .clk_i   (clk_i),     .rst_n_i    (rst_n_i),
    .start_i (y_start_i), .cfg_i      (y_cfg_i),
    .req_o   (ch_req[CH_Y]), .req_o_data (ch_req_data[CH_Y]),
    .gnt_i   (ch_gnt[CH_Y]), .rsp_i      (ch_rsp[CH_Y]),
    .valid_o (y_valid_o), .ready_i    (y_ready_i),
    .data_o  (y_data_o),  .done_o     (y_done_o)
  );

  // Writes never get read data back, so the Z response slot stays unused
  store_sink i_z_sink (
    .clk_i   (clk_i),     .rst_n_i    (rst_n_i),
    .start_i (z_start_i), .cfg_i      (z_cfg_i),
    .valid_i (z_valid_i), .ready_o    (z_ready_o),
    .data_i  (z_data_i),
    .req_o   (ch_req[CH_Z]), .req_o_data (ch_req_data[CH_Z]),
    .gnt_i   (ch_gnt[CH_Z]), .done_o     (z_done_o)
  );

  tcdm_arbiter i_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (ch_req),
    .req_data_i     (ch_req_data),
    .gnt_o          (ch_gnt),
    .rsp_o          (ch_rsp),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rsp_i      (mem_rsp_i)
  );

endmodule

// ==== bench/tcdm_mem_model.sv ====
// --------------------
// TCDM memory model
// Word memory with random grant stalls and one-cycle reads
// --------------------
`timescale 1ns/1ps

module tcdm_mem_model #(
  parameter int unsigned WORDS = 1024,
  parameter logic [31:0] FILL  = 32'h0,
  parameter logic [31:0] SEED  = 32'h1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   stall_en_i,
  input  logic                   req_i,
  input  streamer_pkg::mem_req_t req_data_i,
  output logic                   gnt_o,
  output streamer_pkg::mem_rsp_t rsp_o
);

  import streamer_pkg::*;

  localparam int unsigned IDX_W = $clog2(WORDS);

  data_t            words [WORDS];
  int unsigned      n_writes;
  integer           seed;
  logic [31:0]      rnd;
  logic [IDX_W-1:0] idx;

  assign idx = req_data_i.addr[IDX_W+1:2];

  // Each word starts as its byte address XOR the fill pattern
  initial begin
    seed  = SEED;
    gnt_o = 1'b0;
    rsp_o = '0;
    for (int i = 0; i < WORDS; i++) begin
      words[i] = data_t'(i * 4) ^ FILL;
    end
  end

  // Grant changes on the falling edge, roughly one cycle in four stalls
  always @(negedge clk_i) begin
    rnd   = $random(seed);
    gnt_o = !stall_en_i || (rnd[1:0] != 2'b00);
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_o.rvalid <= 1'b0;
      rsp_o.rdata  <= '0;
      n_writes     <= 0;
    end else begin
      rsp_o.rvalid <= req_i && gnt_o && !req_data_i.we;
      if (req_i && gnt_o) begin
        if (req_data_i.we) begin
          words[idx] <= req_data_i.wdata;
          n_writes   <= n_writes + 1;
        end else begin
          rsp_o.rdata <= words[idx];
        end
      end
    end
  end

endmodule

// ==== bench/streamer_sva.sv ====
// --------------------
// Streamer protocol assertions
// Memory port handshake, read latency and stream valid rules
// --------------------
`timescale 1ns/1ps

module streamer_sva (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   mem_req_o,
  input streamer_pkg::mem_req_t mem_req_data_o,
  input logic                   mem_gnt_i,
  input streamer_pkg::mem_rsp_t mem_rsp_i,
  input logic                   x_valid_o,
  input logic                   x_ready_i,
  input logic                   w_valid_o,
  input logic                   w_ready_i,
  input logic                   y_valid_o,
  input logic                   y_ready_i,
  input logic                   z_valid_i,
  input logic                   z_ready_o
);

  int unsigned fail_cnt = 0;

  property held_until_taken(logic v, logic r);
    @(posedge clk_i) disable iff (!rst_n_i) v && !r |=> v;
  endproperty

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_req_data_o))
    else begin
      fail_cnt++;
      $error("memory request changed before its grant");
    end

  // Read data exactly one cycle after each granted read, and never otherwise
  rvalid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    1'b1 |=> (mem_rsp_i.rvalid == $past(mem_req_o && mem_gnt_i && !mem_req_data_o.we)))
    else begin
      fail_cnt++;
      $error("rvalid does not follow a granted read by one cycle");
    end

  x_valid_held: assert property (held_until_taken(x_valid_o, x_ready_i))
    else begin
      fail_cnt++;
      $error("x stream valid dropped before its transfer");
    end
  w_valid_held: assert property (held_until_taken(w_valid_o, w_ready_i))
    else begin
      fail_cnt++;
      $error("w stream valid dropped before its transfer");
    end
  y_valid_held: assert property (held_until_taken(y_valid_o, y_ready_i))
    else begin
      fail_cnt++;
      $error("y stream valid dropped before its transfer");
    end
  z_valid_held: assert property (held_until_taken(z_valid_i, z_ready_o))
    else begin
      fail_cnt++;
      $error("z stream valid dropped before its transfer");
    end

endmodule

bind redmule_streamer streamer_sva streamer_sva_inst (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .mem_req_o      (mem_req_o),
  .mem_req_data_o (mem_req_data_o),
  .mem_gnt_i      (mem_gnt_i),
  .mem_rsp_i      (mem_rsp_i),
  .x_valid_o      (x_valid_o),
  .x_ready_i      (x_ready_i),
  .w_valid_o      (w_valid_o),
  .w_ready_i      (w_ready_i),
  .y_valid_o      (y_valid_o),
  .y_ready_i      (y_ready_i),
  .z_valid_i      (z_valid_i),
  .z_ready_o      (z_ready_o)
);

// ==== bench/tb_streamer.sv ====
// --------------------
// Streamer testbench
// Load, store and mixed traffic against a memory model
// --------------------
`timescale 1ns/1ps

module tb_streamer;

  import streamer_pkg::*;

  localparam logic [31:0] FILL = 32'h5a3c_96e1;
  localparam logic [31:0] SEED = 32'hba4f_9be4;
  localparam int SOLO_LEN = 8;
  localparam int X_LEN = 12;
  localparam int W_LEN = 9;
  localparam int Y_LEN = 7;
  localparam int Z_LEN = 10;
  // Loads run in tests 2, 3 and 5, the store in tests 4 and 5
  localparam int TOTAL_WORDS = SOLO_LEN + 3 * (X_LEN + W_LEN + Y_LEN) + 2 * Z_LEN;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_WORDS + 300;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic [3:0]       start_vec;
  ch_cfg_t          cfg_drv [4];
  logic [2:0]       ld_ready = 3'b000;
  wire  [2:0]       ld_valid;
  wire  [2:0][31:0] ld_data;
  wire  [3:0]       done_vec;
  logic             z_valid_i = 1'b0;
  data_t            z_data_i = '0;
  wire              z_ready_o;
  logic             mem_req;
  mem_req_t         mem_req_data;
  logic             mem_gnt;
  mem_rsp_t         mem_rsp;
  logic             stall_en = 1'b0;
  bit               rand_mode = 1'b0;
  integer           seed = SEED;
  logic [31:0]      rnd;
  int               errors = 0;
  int               tests_failed = 0;
  int               cycle_cnt = 0;
  int               rx_cnt [3] = '{default: 0};
  int               rx_mark [3] = '{default: 0};
  int               done_cnt [4] = '{default: 0};
  int               done_mark [4] = '{default: 0};
  int               z_sent = 0;
  int               z_total = 0;
  data_t            z_words [$];

  redmule_streamer redmule_streamer_inst (
    .clk_i     (clk_i),        .rst_n_i   (rst_n_i),
    .x_start_i (start_vec[0]), .x_cfg_i   (cfg_drv[0]),  .x_valid_o (ld_valid[0]),
    .x_ready_i (ld_ready[0]),  .x_data_o  (ld_data[0]),  .x_done_o  (done_vec[0]),
    .w_start_i (start_vec[1]), .w_cfg_i   (cfg_drv[1]),  .w_valid_o (ld_valid[1]),
    .w_ready_i (ld_ready[1]),  .w_data_o  (ld_data[1]),  .w_done_o  (done_vec[1]),
    .y_start_i (start_vec[2]), .y_cfg_i   (cfg_drv[2]),  .y_valid_o (ld_valid[2]),
    .y_ready_i (ld_ready[2]),  .y_data_o  (ld_data[2]),  .y_done_o  (done_vec[2]),
    .z_start_i (start_vec[3]), .z_cfg_i   (cfg_drv[3]),  .z_valid_i (z_valid_i),
    .z_ready_o (z_ready_o),    .z_data_i  (z_data_i),    .z_done_o  (done_vec[3]),
    .mem_req_o (mem_req),      .mem_req_data_o (mem_req_data),
    .mem_gnt_i (mem_gnt),      .mem_rsp_i (mem_rsp)
  );

  tcdm_mem_model #(
    .FILL (FILL),
    .SEED (SEED)
  ) mem_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_en_i (stall_en),
    .req_i      (mem_req),
    .req_data_i (mem_req_data),
    .gnt_o      (mem_gnt),
    .rsp_o      (mem_rsp)
  );

  function automatic ch_cfg_t make_cfg(addr_t base, addr_t stride, len_t len);
    ch_cfg_t c;
    c.base   = base;
    c.stride = stride;
    c.len    = len;
    return c;
  endfunction

  // Word i of a load is the fill value of its strided byte address
  function automatic data_t expected_word(ch_cfg_t cfg, int unsigned i);
    addr_t addr;
    addr = cfg.base + addr_t'(i) * cfg.stride;
    return addr ^ FILL;
  endfunction

  function automatic string stream_name(int ch);
    case (ch)
      0: stream_name = "x";
      1: stream_name = "w";
      2: stream_name = "y";
      default: stream_name = "z";
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Consumer ready and Z producer, both on the falling edge
  always @(negedge clk_i) begin
    rnd = $random(seed);
    if (!rst_n_i) begin
      ld_ready  = 3'b000;
      z_valid_i = 1'b0;
    end else begin
      ld_ready = rand_mode ? (rnd[2:0] | rnd[5:3]) : 3'b111;
      if (z_sent < z_total) begin
        // Once raised, valid stays up until the word is taken
        if (!z_valid_i) begin
          z_valid_i = !(rand_mode && rnd[7:6] == 2'b00);
        end
        z_data_i = z_words[z_sent];
      end else begin
        z_valid_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      for (int ch = 0; ch < 3; ch++) begin
        if (ld_valid[ch] && ld_ready[ch]) begin
          check_value({stream_name(ch), "_data_o"}, ld_data[ch],
                      expected_word(cfg_drv[ch], rx_cnt[ch] - rx_mark[ch]));
          rx_cnt[ch]++;
        end
      end
      for (int ch = 0; ch < 4; ch++) begin
        if (done_vec[ch]) begin
          done_cnt[ch]++;
        end
      end
      if (z_valid_i && z_ready_o) begin
        z_sent++;
      end
    end
  end

  task automatic run_test(input int num, input string title, input logic [3:0] mask,
                          input bit rnd_on, input bit stall_on, input ch_cfg_t cfgs [4]);
    int    err_before;
    int    zmark;
    int    wr_before;
    addr_t addr;
    err_before = errors;
    zmark      = z_total;
    @(posedge clk_i);
    rand_mode = rnd_on;
    stall_en  = stall_on;
    if (mask[3]) begin
      for (int i = 0; i < cfgs[3].len; i++) begin
        z_words.push_back({16'(num) + 16'hd000, 16'(i * 37 + 5)});
      end
      z_total = z_total + cfgs[3].len;
    end
    @(negedge clk_i);
    wr_before = mem_inst.n_writes;
    for (int ch = 0; ch < 4; ch++) begin
      done_mark[ch] = done_cnt[ch];
      if (ch < 3) begin
        rx_mark[ch] = rx_cnt[ch];
      end
      cfg_drv[ch] = cfgs[ch];
    end
    start_vec = mask;
    @(negedge clk_i);
    start_vec = 4'b0000;
    for (int ch = 0; ch < 4; ch++) begin
      while (mask[ch] && done_cnt[ch] == done_mark[ch]) begin
        @(negedge clk_i);
      end
    end
    // Idle time shows up any late words or extra done pulses
    repeat (10) @(negedge clk_i);
    for (int ch = 0; ch < 4; ch++) begin
      check_value({stream_name(ch), "_done_o pulses"}, done_cnt[ch] - done_mark[ch],
                  mask[ch] ? 1 : 0);
      if (ch < 3) begin
        check_value({stream_name(ch), " words"}, rx_cnt[ch] - rx_mark[ch],
                    mask[ch] ? cfgs[ch].len : 0);
      end
    end
    if (mask[3]) begin
      check_value("memory writes", mem_inst.n_writes - wr_before, cfgs[3].len);
      for (int i = 0; i < cfgs[3].len; i++) begin
        addr = cfgs[3].base + addr_t'(i) * cfgs[3].stride;
        check_value($sformatf("mem[0x%08h]", addr), mem_inst.words[addr[11:2]],
                    z_words[zmark + i]);
      end
    end
    if (errors == err_before) begin
      $display("Test %0d %s: ok", num, title);
    end else begin
      $display("Test %0d %s: %0d errors", num, title, errors - err_before);
      tests_failed++;
    end
  endtask

  initial begin
    ch_cfg_t solo [4];
    ch_cfg_t loads [4];
    ch_cfg_t store [4];
    ch_cfg_t mixed [4];
    int      sva_fails;
    rst_n_i   = 1'b0;
    start_vec = 4'b0000;
    for (int ch = 0; ch < 4; ch++) begin
      cfg_drv[ch] = '0;
    end
    solo     = '{default: '0};
    solo[0]  = make_cfg(32'h100, 32'd4, len_t'(SOLO_LEN));
    loads[0] = make_cfg(32'h200, 32'd4, len_t'(X_LEN));
    loads[1] = make_cfg(32'h400, 32'd8, len_t'(W_LEN));
    loads[2] = make_cfg(32'h800, 32'd12, len_t'(Y_LEN));
    loads[3] = '0;
    store    = '{default: '0};
    store[3] = make_cfg(32'ha00, 32'd8, len_t'(Z_LEN));
    mixed    = loads;
    mixed[3] = make_cfg(32'hc00, 32'd4, len_t'(Z_LEN));

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    run_test(1, "single X load", 4'b0001, 1'b0, 1'b0, solo);
    run_test(2, "concurrent loads", 4'b0111, 1'b0, 1'b0, loads);
    run_test(3, "loads with ready stalls", 4'b0111, 1'b1, 1'b0, loads);
    run_test(4, "Z store", 4'b1000, 1'b0, 1'b0, store);
    run_test(5, "mixed traffic with grant stalls", 4'b1111, 1'b1, 1'b1, mixed);

    sva_fails = redmule_streamer_inst.streamer_sva_inst.fail_cnt;
    $display("Tests: 5, failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_failed, errors, sva_fails);
    if (errors == 0 && tests_failed == 0 && sva_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
rtl/streamer_pkg.sv
rtl/stream_fifo.sv
rtl/load_source.sv
rtl/store_sink.sv
rtl/tcdm_arbiter.sv
rtl/redmule_streamer.sv
bench/tcdm_mem_model.sv
bench/streamer_sva.sv
bench/tb_streamer.sv

// ==== Bender.yml ====
package:
  name: redmule_streamer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/streamer_pkg.sv
      - rtl/stream_fifo.sv
      - rtl/load_source.sv
      - rtl/store_sink.sv
      - rtl/tcdm_arbiter.sv
      - rtl/redmule_streamer.sv
  - target: test
    files:
      - bench/tcdm_mem_model.sv
      - bench/streamer_sva.sv
      - bench/tb_streamer.sv
